//--- Bender.yml
package:
  name: spi_master

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - spi_link_pkg.sv
      - byte_stream_pkg.sv
      - sck_edge_gen.sv
      - spi_tx_engine.sv
      - spi_rx_capture.sv
      - rx_stream_out.sv
      - spi_master_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_spi_slave_model.sv
      - tb_spi_master.sv

//--- byte_stream_pkg.sv
`include "spi_master_settings.svh"

// ============================
// Stream side types
// ============================
package byte_stream_pkg;

    // One payload byte on either stream
    typedef logic [`SPI_BYTE_BITS-1:0] byte_t;

endpackage

//--- rx_stream_out.sv
`timescale 1ns/1ps

module rx_stream_out
    import byte_stream_pkg::*;
(
    input  logic  aclk,
    input  logic  aresetn,
    input  logic  byte_done,
    input  byte_t rx_byte,
    output byte_t m_axis_tdata,
    output logic  m_axis_tvalid,
    input  logic  m_axis_tready,
    output logic  stat_rx_overflow
);

    logic out_free;

    // Output slot empty or emptied this cycle
    assign out_free = !m_axis_tvalid || m_axis_tready;

    // ============================
    // Receive stream register
    // ============================
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            m_axis_tvalid <= 1'b0;
        end else if (byte_done) begin
            // New byte, or the held one still pending
            m_axis_tvalid <= 1'b1;
        end else if (m_axis_tready) begin
            m_axis_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (byte_done && out_free) begin
            m_axis_tdata <= rx_byte;
        end
    end

    // Byte lost when nothing can take it
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            stat_rx_overflow <= 1'b0;
        end else begin
            stat_rx_overflow <= byte_done && !out_free;
        end
    end

    // ============================
    // Stream checks
    // ============================
    assert property (@(posedge aclk)
        $rose(aresetn) |-> !m_axis_tvalid)
        else $error("m_axis_tvalid high in first cycle after reset");

    assert property (@(posedge aclk) disable iff (!aresetn)
        m_axis_tvalid && !m_axis_tready |=> $stable(m_axis_tdata))
        else $error("m_axis_tdata changed while stalled");

    assert property (@(posedge aclk) disable iff (!aresetn)
        m_axis_tvalid |-> !$isunknown(m_axis_tdata))
        else $error("m_axis_tdata unknown while valid");

endmodule

//--- sck_edge_gen.sv
`timescale 1ns/1ps
`include "spi_master_settings.svh"

module sck_edge_gen
    import spi_link_pkg::*;
(
    input  logic aclk,
    input  logic aresetn,
    output logic sck_rise,
    output logic sck_fall
);

    // Ratio sanity, checked once at elaboration start
    initial begin
        assert ((`SPI_CLK_RATIO % 2 == 0) && (`SPI_CLK_RATIO >= 4))
            else $error("SPI_CLK_RATIO must be even and at least 4");
    end

    edge_cnt_t edge_cnt;

    // ============================
    // Free-running divider
    // ============================
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            edge_cnt <= '0;
        end else if (edge_cnt == edge_cnt_t'(`SPI_CLK_RATIO - 1)) begin
            edge_cnt <= '0;
        end else begin
            edge_cnt <= edge_cnt + 1'b1;
        end
    end

    // Strobes, one cycle behind the count
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            sck_rise <= 1'b0;
            sck_fall <= 1'b0;
        end else begin
            sck_rise <= (edge_cnt == '0);
            // Half a period later
            sck_fall <= (edge_cnt == edge_cnt_t'(`SPI_CLK_RATIO / 2));
        end
    end

endmodule

//--- sources.f
+incdir+.
spi_link_pkg.sv
byte_stream_pkg.sv
sck_edge_gen.sv
spi_tx_engine.sv
spi_rx_capture.sv
rx_stream_out.sv
spi_master_top.sv
tb_spi_slave_model.sv
tb_spi_master.sv

//--- spi_link_pkg.sv
`include "spi_master_settings.svh"

// ============================
// SPI bus side types
// ============================
package spi_link_pkg;

    // Bit position inside one transfer
    typedef logic [$clog2(`SPI_BYTE_BITS)-1:0] bit_idx_t;

    // sck divider count, 0 .. SPI_CLK_RATIO-1
    typedef logic [$clog2(`SPI_CLK_RATIO)-1:0] edge_cnt_t;

    // Transmit FSM
    typedef enum logic [2:0] {
        ST_RESET,   // one cycle out of reset
        ST_IDLE,    // ss high, waiting for a held byte
        ST_ALIGN,   // waiting for the next fall strobe
        ST_LEAD_IN, // ss low, bit 0 on mosi, sck still low
        ST_SHIFT    // sck toggling, eight periods per byte
    } tx_state_t;

endpackage

//--- spi_master_settings.svh
`ifndef SPI_MASTER_SETTINGS_SVH
`define SPI_MASTER_SETTINGS_SVH

// ============================
// SPI master build constants
// ============================

// aclk cycles per sck period
// Even, and no less than 4
`define SPI_CLK_RATIO 8

// Bits per SPI transfer
`define SPI_BYTE_BITS 8

// Half-period split of one sck period
// rise strobe at count 0, fall strobe at count SPI_CLK_RATIO/2
// Both strobes are one aclk wide

`endif

//--- spi_master_top.sv
`timescale 1ns/1ps

module spi_master_top
    import spi_link_pkg::*;
    import byte_stream_pkg::*;
(
    input  logic  aclk,
    input  logic  aresetn,
    input  byte_t s_axis_tdata,
    input  logic  s_axis_tvalid,
    output logic  s_axis_tready,
    output byte_t m_axis_tdata,
    output logic  m_axis_tvalid,
    input  logic  m_axis_tready,
    output logic  stat_rx_overflow,
    output logic  sck,
    output logic  ss,
    output logic  mosi,
    input  logic  miso
);

    // Divider strobes
    logic     sck_rise;
    logic     sck_fall;
    // Engine to capture and output stage
    logic     sample_strobe;
    bit_idx_t bit_idx;
    logic     byte_done;
    byte_t    rx_byte;

    // ============================
    // Pacing and transmit
    // ============================
    sck_edge_gen u_edge_gen (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .sck_rise (sck_rise),
        .sck_fall (sck_fall)
    );

    spi_tx_engine u_tx_engine (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .sck_rise      (sck_rise),
        .sck_fall      (sck_fall),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .sck           (sck),
        .ss            (ss),
        .mosi          (mosi),
        .sample_strobe (sample_strobe),
        .bit_idx       (bit_idx),
        .byte_done     (byte_done)
    );

    // ============================
    // Receive
    // ============================
    spi_rx_capture u_rx_capture (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .miso          (miso),
        .sample_strobe (sample_strobe),
        .bit_idx       (bit_idx),
        .rx_byte       (rx_byte)
    );

    rx_stream_out u_rx_out (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .byte_done        (byte_done),
        .rx_byte          (rx_byte),
        .m_axis_tdata     (m_axis_tdata),
        .m_axis_tvalid    (m_axis_tvalid),
        .m_axis_tready    (m_axis_tready),
        .stat_rx_overflow (stat_rx_overflow)
    );

endmodule

//--- spi_rx_capture.sv
`timescale 1ns/1ps

module spi_rx_capture
    import spi_link_pkg::*;
    import byte_stream_pkg::*;
(
    input  logic     aclk,
    input  logic     aresetn,
    input  logic     miso,
    input  logic     sample_strobe,
    input  bit_idx_t bit_idx,
    output byte_t    rx_byte
);

    // ============================
    // miso synchronizer
    // ============================
    logic miso_meta;
    logic miso_sync;

    // Two flops, pin is asynchronous to aclk
    always_ff @(posedge aclk) begin
        miso_meta <= miso;
        miso_sync <= miso_meta;
    end

    // ============================
    // Bit capture
    // ============================
    // Strobe sits one cycle after the fall strobe
    // so the synchronized sample is taken mid low half
    always_ff @(posedge aclk) begin
        if (sample_strobe) begin
            rx_byte[bit_idx] <= miso_sync;
        end
    end

    // Strobe and index fully driven once out of reset
    assert property (@(posedge aclk) disable iff (!aresetn)
        !$isunknown({sample_strobe, bit_idx}))
        else $error("sample_strobe or bit_idx unknown");

endmodule

//--- spi_tx_engine.sv
`timescale 1ns/1ps

module spi_tx_engine
    import spi_link_pkg::*;
    import byte_stream_pkg::*;
(
    input  logic     aclk,
    input  logic     aresetn,
    input  logic     sck_rise,
    input  logic     sck_fall,
    input  byte_t    s_axis_tdata,
    input  logic     s_axis_tvalid,
    output logic     s_axis_tready,
    output logic     sck,
    output logic     ss,
    output logic     mosi,
    output logic     sample_strobe,
    output bit_idx_t bit_idx,
    output logic     byte_done
);

    tx_state_t state;
    tx_state_t state_next;

    // Half-period count within a byte
    // even = sck high, odd = sck low
    logic [$bits(bit_idx_t):0] half_cnt;

    byte_t hold_byte;
    logic  hold_valid;
    byte_t shift_byte;
    logic  last_rise;
    logic  tx_load;

    // Bit being driven or sampled
    assign bit_idx = half_cnt[$bits(bit_idx_t):1];

    // Rise strobe that closes the final low half of a byte
    assign last_rise = (state == ST_SHIFT) && sck_rise && (&half_cnt);

    // Holding register moves into the shifter
    assign tx_load = hold_valid && ((state == ST_IDLE) || last_rise);

    // ============================
    // Transmit FSM
    // ============================
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= ST_RESET;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_RESET: state_next = ST_IDLE;
            ST_IDLE: begin
                // Skip align when already on a fall strobe
                if (hold_valid) begin
                    state_next = sck_fall ? ST_LEAD_IN : ST_ALIGN;
                end
            end
            ST_ALIGN: begin
                if (sck_fall) begin
                    state_next = ST_LEAD_IN;
                end
            end
            ST_LEAD_IN: begin
                if (sck_rise) begin
                    state_next = ST_SHIFT;
                end
            end
            ST_SHIFT: begin
                // Keep going when the next byte is already held
                if (last_rise && !hold_valid) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_RESET;
        endcase
    end

    // Wraps to zero at the last rise on back-to-back bytes
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            half_cnt <= '0;
        end else if (state == ST_SHIFT) begin
            if (sck_rise || sck_fall) begin
                half_cnt <= half_cnt + 1'b1;
            end
        end else begin
            half_cnt <= '0;
        end
    end

    // ============================
    // Transmit stream side
    // ============================
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            s_axis_tready <= 1'b0;
        end else if (s_axis_tready && s_axis_tvalid) begin
            // One dead cycle after each transfer
            s_axis_tready <= 1'b0;
        end else if (tx_load) begin
            s_axis_tready <= 1'b1;
        end else begin
            s_axis_tready <= !hold_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            hold_valid <= 1'b0;
        end else if (s_axis_tready && s_axis_tvalid) begin
            hold_valid <= 1'b1;
        end else if (tx_load) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (s_axis_tready && s_axis_tvalid) begin
            hold_byte <= s_axis_tdata;
        end
        if (tx_load) begin
            shift_byte <= hold_byte;
        end
    end

    // ============================
    // SPI pins and sample strobes
    // ============================
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ss            <= 1'b1;
            sck           <= 1'b0;
            mosi          <= 1'b0;
            sample_strobe <= 1'b0;
            byte_done     <= 1'b0;
        end else begin
            ss  <= !((state == ST_LEAD_IN) || (state == ST_SHIFT));
            sck <= (state == ST_SHIFT) && !half_cnt[0];
            // Bit 0 already present during lead-in
            if ((state == ST_LEAD_IN) || (state == ST_SHIFT)) begin
                mosi <= shift_byte[bit_idx];
            end else begin
                mosi <= 1'b0;
            end
            sample_strobe <= (state == ST_SHIFT) && sck_fall;
            // End of byte, after the eighth sample
            byte_done <= sample_strobe && (&bit_idx);
        end
    end

    // Never ready with a full holding register
    assert property (@(posedge aclk) disable iff (!aresetn)
        s_axis_tready |-> !hold_valid)
        else $error("s_axis_tready high while holding register full");

    // sck parked low outside a select window
    assert property (@(posedge aclk) disable iff (!aresetn)
        ss |-> !sck)
        else $error("sck high while ss deasserted");

endmodule

//--- tb_spi_master.sv
`timescale 1ns/1ps
`include "spi_master_settings.svh"

module tb_spi_master
    import byte_stream_pkg::*;
();

    // 1 + 16 + 6 + 3 bytes over all tests
    localparam int num_bytes   = 26;
    localparam int wait_limit  = 24 * 10 * `SPI_CLK_RATIO;
    // Bytes x 10 sck periods x 20 ns, plus idle gaps
    localparam int watchdog_ns = (num_bytes * 10 + 200) * `SPI_CLK_RATIO * 20;

    logic  aclk = 1'b0;
    logic  aresetn;
    byte_t s_axis_tdata;
    logic  s_axis_tvalid;
    logic  s_axis_tready;
    byte_t m_axis_tdata;
    logic  m_axis_tvalid;
    logic  m_axis_tready;
    logic  stat_rx_overflow;
    logic  sck;
    logic  ss;
    logic  mosi;
    logic  miso;
    byte_t slave_resp;
    byte_t slave_rec_byte;
    int    slave_rec_cnt;

    // Stimulus, expected responses and observed traffic, by byte number
    byte_t  tx_mem   [0:63];
    byte_t  resp_mem [0:63];
    byte_t  sent_log [0:63];
    byte_t  rec_log  [0:63];
    byte_t  rx_log   [0:63];
    int     sent_cnt     = 0;
    int     rx_cnt       = 0;
    int     ovf_cnt      = 0;
    int     sck_rise_cnt = 0;
    int     ss_rise_cnt  = 0;
    logic   handshake_q  = 1'b0;
    integer seed         = 32'hee5d;

    spi_master_top DUT (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .s_axis_tdata     (s_axis_tdata),
        .s_axis_tvalid    (s_axis_tvalid),
        .s_axis_tready    (s_axis_tready),
        .m_axis_tdata     (m_axis_tdata),
        .m_axis_tvalid    (m_axis_tvalid),
        .m_axis_tready    (m_axis_tready),
        .stat_rx_overflow (stat_rx_overflow),
        .sck              (sck),
        .ss               (ss),
        .mosi             (mosi),
        .miso             (miso)
    );

    // Response picked by the number of bytes already seen
    assign slave_resp = resp_mem[slave_rec_cnt[5:0]];

    tb_spi_slave_model u_slave (
        .sck       (sck),
        .ss        (ss),
        .mosi      (mosi),
        .miso      (miso),
        .resp_byte (slave_resp),
        .rec_byte  (slave_rec_byte),
        .rec_cnt   (slave_rec_cnt)
    );

    // 20 ns period
    always #10 aclk = ~aclk;

    // ============================
    // Error reporting
    // ============================
    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("error at %0t ns: %s expected %0h, actual %0h", $time, name, expected, actual);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t ns: %s", $time, what);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    // ============================
    // Bus monitors
    // ============================
    always @(posedge aclk) begin
        if (aresetn) begin
            assert (!(ss && sck)) else report_failure("sck high while ss is high");
            // Ready drops for one cycle after every transfer
            if (handshake_q) begin
                assert (!s_axis_tready) else report_mismatch("s_axis_tready", 0, s_axis_tready);
            end
            // One byte shifting plus one held, never more
            assert (sent_cnt - slave_rec_cnt <= 2)
                else report_failure("more than two bytes accepted ahead of the SPI bus");
        end
        handshake_q <= s_axis_tvalid && s_axis_tready;
        if (s_axis_tvalid && s_axis_tready) begin
            sent_log[sent_cnt] <= s_axis_tdata;
            sent_cnt           <= sent_cnt + 1;
        end
        if (m_axis_tvalid && m_axis_tready) begin
            rx_log[rx_cnt] <= m_axis_tdata;
            rx_cnt         <= rx_cnt + 1;
        end
        if (stat_rx_overflow) begin
            ovf_cnt <= ovf_cnt + 1;
        end
    end

    always @(slave_rec_cnt) begin
        if (slave_rec_cnt > 0) begin
            rec_log[slave_rec_cnt - 1] = slave_rec_byte;
        end
    end

    // sck edges inside a select window
    always @(posedge sck) begin
        if (ss === 1'b0) begin
            sck_rise_cnt++;
        end
    end

    always @(posedge ss) begin
        ss_rise_cnt++;
    end

    // ============================
    // Helpers
    // ============================
    task automatic idle_cycles(input int n);
        repeat (n) @(posedge aclk);
    endtask

    // Valid held high across the whole burst
    task automatic send_burst(input int first, input int n);
        for (int i = 0; i < n; i++) begin
            s_axis_tdata  <= tx_mem[first + i];
            s_axis_tvalid <= 1'b1;
            do begin
                @(posedge aclk);
            end while (!s_axis_tready);
        end
        s_axis_tvalid <= 1'b0;
    endtask

    task automatic wait_for_counts(input int rec_target, input int rx_target);
        int cycles;
        cycles = 0;
        while ((slave_rec_cnt < rec_target) || (rx_cnt < rx_target)) begin
            @(posedge aclk);
            cycles++;
            if (cycles > wait_limit) begin
                report_failure("timed out waiting for bytes on SPI or the receive stream");
            end
        end
    endtask

    // Stream order, mosi content and optionally the returned bytes
    task automatic check_bytes(input int first, input int n, input bit with_rx);
        assert (sent_cnt == first + n) else report_mismatch("accepted bytes", first + n, sent_cnt);
        for (int i = first; i < first + n; i++) begin
            assert (sent_log[i] === tx_mem[i])
                else report_mismatch("s_axis_tdata accepted", tx_mem[i], sent_log[i]);
            assert (rec_log[i] === tx_mem[i])
                else report_mismatch("mosi byte", tx_mem[i], rec_log[i]);
            if (with_rx) begin
                assert (rx_log[i] === resp_mem[i])
                    else report_mismatch("m_axis_tdata", resp_mem[i], rx_log[i]);
            end
        end
    endtask

    // ============================
    // Tests
    // ============================
    task automatic test_reset_state();
        int waited;
        waited = 0;
        @(posedge aclk);
        assert (ss === 1'b1) else report_mismatch("ss", 1, ss);
        assert (sck === 1'b0) else report_mismatch("sck", 0, sck);
        assert (m_axis_tvalid === 1'b0) else report_mismatch("m_axis_tvalid", 0, m_axis_tvalid);
        assert (stat_rx_overflow === 1'b0)
            else report_mismatch("stat_rx_overflow", 0, stat_rx_overflow);
        while ((s_axis_tready !== 1'b1) && (waited < 2)) begin
            @(posedge aclk);
            waited++;
        end
        assert (s_axis_tready === 1'b1) else report_mismatch("s_axis_tready", 1, s_axis_tready);
    endtask

    task automatic test_single_byte();
        int base;
        int rises;
        idle_cycles(`SPI_CLK_RATIO);
        base           = sent_cnt;
        rises          = sck_rise_cnt;
        tx_mem[base]   = 8'hc3;
        resp_mem[base] = 8'h5a;
        send_burst(base, 1);
        wait_for_counts(base + 1, base + 1);
        idle_cycles(`SPI_CLK_RATIO);
        assert (sck_rise_cnt - rises == 8)
            else report_mismatch("sck rising edges", 8, sck_rise_cnt - rises);
        check_bytes(base, 1, 1'b1);
    endtask

    task automatic test_back_to_back();
        int base;
        int ss_base;
        idle_cycles(2 * `SPI_CLK_RATIO);
        base    = sent_cnt;
        ss_base = ss_rise_cnt;
        for (int i = 0; i < 16; i++) begin
            tx_mem[base + i]   = byte_t'($random(seed));
            resp_mem[base + i] = byte_t'($random(seed));
        end
        send_burst(base, 16);
        wait_for_counts(base + 16, base + 16);
        idle_cycles(2 * `SPI_CLK_RATIO);
        // Only the final deselect
        assert (ss_rise_cnt - ss_base == 1)
            else report_mismatch("ss rising edges", 1, ss_rise_cnt - ss_base);
        check_bytes(base, 16, 1'b1);
    endtask

    task automatic test_tx_backpressure();
        int base;
        idle_cycles(2 * `SPI_CLK_RATIO);
        base = sent_cnt;
        for (int i = 0; i < 6; i++) begin
            tx_mem[base + i]   = byte_t'($random(seed));
            resp_mem[base + i] = byte_t'($random(seed));
        end
        send_burst(base, 6);
        wait_for_counts(base + 6, base + 6);
        check_bytes(base, 6, 1'b1);
    endtask

    task automatic test_rx_overflow();
        int base;
        int rx_base;
        int ovf_base;
        idle_cycles(2 * `SPI_CLK_RATIO);
        base     = sent_cnt;
        rx_base  = rx_cnt;
        ovf_base = ovf_cnt;
        m_axis_tready <= 1'b0;
        resp_mem[base]     = 8'h3c;
        resp_mem[base + 1] = 8'h96;
        resp_mem[base + 2] = 8'he1;
        for (int i = 0; i < 3; i++) begin
            tx_mem[base + i] = byte_t'($random(seed));
        end
        send_burst(base, 3);
        wait_for_counts(base + 3, rx_base);
        // Let the last byte_done and overflow pulse land
        idle_cycles(`SPI_CLK_RATIO);
        assert (m_axis_tvalid === 1'b1) else report_mismatch("m_axis_tvalid", 1, m_axis_tvalid);
        assert (m_axis_tdata === resp_mem[base])
            else report_mismatch("m_axis_tdata", resp_mem[base], m_axis_tdata);
        assert (ovf_cnt - ovf_base == 2)
            else report_mismatch("stat_rx_overflow pulses", 2, ovf_cnt - ovf_base);
        m_axis_tready <= 1'b1;
        idle_cycles(4);
        assert (rx_cnt == rx_base + 1) else report_mismatch("delivered bytes", 1, rx_cnt - rx_base);
        assert (rx_log[rx_base] === resp_mem[base])
            else report_mismatch("m_axis_tdata", resp_mem[base], rx_log[rx_base]);
        check_bytes(base, 3, 1'b0);
    endtask

    // ============================
    // Sequence and watchdog
    // ============================
    initial begin
        aresetn       <= 1'b0;
        s_axis_tdata  <= '0;
        s_axis_tvalid <= 1'b0;
        m_axis_tready <= 1'b1;
        repeat (3) @(posedge aclk);
        aresetn <= 1'b1;
        test_reset_state();
        test_single_byte();
        test_back_to_back();
        test_tx_backpressure();
        test_rx_overflow();
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        report_failure("watchdog expired before all tests finished");
    end

endmodule

//--- tb_spi_slave_model.sv
`timescale 1ns/1ps

module tb_spi_slave_model
    import byte_stream_pkg::*;
(
    input  logic  sck,
    input  logic  ss,
    input  logic  mosi,
    output logic  miso,
    // Response for the byte now on the bus
    input  byte_t resp_byte,
    // Last byte seen on mosi, and how many so far
    output byte_t rec_byte,
    output int    rec_cnt
);

    byte_t shift_in;
    int    bit_pos;

    initial begin
        miso     = 1'b0;
        rec_byte = '0;
        rec_cnt  = 0;
        shift_in = '0;
        bit_pos  = 0;
    end

    // Select falls, bit 0 goes out before the first edge
    always @(negedge ss) begin
        bit_pos = 0;
        miso    = resp_byte[0];
    end

    // Launch on rising sck
    always @(posedge sck) begin
        if (ss === 1'b0) begin
            miso = resp_byte[bit_pos];
        end
    end

    // ============================
    // Capture on falling sck, LSB first
    // ============================
    always @(negedge sck) begin
        if (ss === 1'b0) begin
            shift_in[bit_pos] = mosi;
            if (bit_pos == 7) begin
                // Byte complete, next response selected by the count
                rec_byte = shift_in;
                rec_cnt  = rec_cnt + 1;
                bit_pos  = 0;
            end else begin
                bit_pos = bit_pos + 1;
            end
        end
    end

endmodule
